// File: Makefile
# Verilator build and run of the touch core testbench

VERILATOR ?= verilator
TOP       ?= touch_core_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# pass or fail comes from the log, not from the pipe status
run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/mpr121_bus_model.sv
// ========================================
// mpr121_bus_model
// behavioral MPR121 register-access controller
// register array, random busy time and
// fail injection on reads
// ========================================
`timescale 1ns/1ps

module mpr121_bus_model
	import touch_pkg::*;
(
	input  logic      i_CLK,
	input  logic      i_RST,
	input  reg_addr_t i_reg_addr,
	input  reg_data_t i_wr_data,
	input  logic      i_wr_en,
	input  logic      i_rd_en,
	input  logic      i_load_en,   // testbench preload of one register
	input  reg_addr_t i_load_addr,
	input  reg_data_t i_load_data,
	input  logic      i_fail_arm,  // reads fail while set
	output reg_data_t o_rd_data,
	output logic      o_busy,
	output logic      o_fail
);

	reg_data_t r_regs [256];
	int        r_busy_left;

	always @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			for (int a = 0; a < 256; a++)
				r_regs[a] <= 8'(a * 37) ^ 8'h5A; // differs per address
			o_rd_data   <= '0;
			o_busy      <= 1'b0;
			o_fail      <= 1'b0;
			r_busy_left <= 0;
		end else begin
			if (i_load_en)
				r_regs[i_load_addr] <= i_load_data;
			if (i_wr_en || i_rd_en) begin
				o_busy      <= 1'b1; // raised on the edge that sees the enable
				r_busy_left <= 1 + int'($urandom % 6);
				o_fail      <= i_rd_en && i_fail_arm;
				o_rd_data   <= r_regs[i_reg_addr]; // held until the next access
				if (i_wr_en)
					r_regs[i_reg_addr] <= i_wr_data;
			end else if (r_busy_left > 1) begin
				r_busy_left <= r_busy_left - 1;
			end else begin
				o_busy <= 1'b0;
			end
		end
	end

endmodule

// File: dv/touch_core_tb.sv
// ========================================
// touch_core_tb
// drives host commands against an MPR121 bus
// model, checks writes, polling and frames
// ========================================
`timescale 1ns/1ps

module touch_core_tb;
	import touch_pkg::*;

	localparam int TIMEOUT_CYCLES = 20000; // full run needs well under 2000

	// expected setting writes in order
	localparam logic [7:0] EXP_ADDR [14] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31,
		8'h32, 8'h33, 8'h34, 8'h35, 8'h5B, 8'h5C, 8'h5D};
	localparam logic [7:0] EXP_DATA [14] = '{
		8'h01, 8'h01, 8'h0E, 8'h00, 8'h01, 8'h05, 8'h01,
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h10, 8'h20};

	logic          i_CLK;
	logic          i_RST;
	host_word_t    i_uart_rx_data;
	logic          i_uart_rx_valid;
	logic          i_uart_tx_ready;
	host_frame_t   o_uart_tx_data;
	logic          o_uart_tx_valid;
	reg_data_t     i_mpr_rd_data;
	logic          i_mpr_init_done;
	logic          i_mpr_busy;
	logic          i_mpr_fail;
	reg_addr_t     o_mpr_reg_addr;
	reg_data_t     o_mpr_wr_data;
	logic          o_mpr_wr_en;
	logic          o_mpr_rd_en;
	touch_status_t o_touch_status;
	logic          o_chip_set;
	logic          o_run_set;
	logic          o_core_busy;
	logic          o_error;
	logic          load_en;
	reg_addr_t     load_addr;
	reg_data_t     load_data;
	logic          fail_arm;

	int            cycle_count = 0;
	int            wr_count = 0;
	int            rd_count = 0;
	int            poll_reads = 0;
	reg_addr_t     poll_addr = 8'h00; // status 0 first, then alternating
	reg_addr_t     last_wr_addr = '0;
	reg_data_t     last_wr_data = '0;
	host_frame_t   frames [$];

	touch_core i_touch_core (.*);

	mpr121_bus_model u_bus (
		.i_CLK       (i_CLK),
		.i_RST       (i_RST),
		.i_reg_addr  (o_mpr_reg_addr),
		.i_wr_data   (o_mpr_wr_data),
		.i_wr_en     (o_mpr_wr_en),
		.i_rd_en     (o_mpr_rd_en),
		.i_load_en   (load_en),
		.i_load_addr (load_addr),
		.i_load_data (load_data),
		.i_fail_arm  (fail_arm),
		.o_rd_data   (i_mpr_rd_data),
		.o_busy      (i_mpr_busy),
		.o_fail      (i_mpr_fail)
	);

	initial begin
		i_CLK = 1'b0;
		forever #20 i_CLK = ~i_CLK;
	end

	task automatic report_mismatch(input string name, input logic [79:0] got,
		input logic [79:0] exp);
		$display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		$display("Checks failed");
		$fatal(1);
	endtask

	// ========================================
	// bus and UART monitors
	// ========================================
	always @(posedge i_CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES)
			report_error("run did not finish within the cycle limit");
		if (!i_RST && o_mpr_wr_en) begin
			if (wr_count < 14) begin
				assert (o_mpr_reg_addr == EXP_ADDR[wr_count]
					&& o_mpr_wr_data == EXP_DATA[wr_count])
					else report_mismatch("o_mpr_reg_addr/o_mpr_wr_data",
						80'({o_mpr_reg_addr, o_mpr_wr_data}),
						80'({EXP_ADDR[wr_count], EXP_DATA[wr_count]}));
			end
			last_wr_addr <= o_mpr_reg_addr;
			last_wr_data <= o_mpr_wr_data;
			wr_count     <= wr_count + 1;
		end
		if (!i_RST && o_mpr_rd_en) begin
			rd_count <= rd_count + 1;
			if (o_core_busy) begin // polling read
				assert (o_mpr_reg_addr == poll_addr)
					else report_mismatch("o_mpr_reg_addr",
						80'(o_mpr_reg_addr), 80'(poll_addr));
				poll_addr  <= poll_addr ^ 8'h01;
				poll_reads <= poll_reads + 1;
			end
		end
		if (!i_RST && o_uart_tx_valid)
			frames.push_back(o_uart_tx_data);
	end

	assert property (@(posedge i_CLK) disable iff (i_RST)
		!i_mpr_init_done |-> !(o_mpr_wr_en || o_mpr_rd_en))
		else report_error("bus enable fired before init done");
	assert property (@(posedge i_CLK) disable iff (i_RST)
		(o_mpr_wr_en || o_mpr_rd_en) |=> !(o_mpr_wr_en || o_mpr_rd_en))
		else report_error("bus enable longer than one cycle");
	assert property (@(posedge i_CLK) disable iff (i_RST)
		$rose(o_chip_set) |-> (wr_count == 14))
		else report_mismatch("wr_count", 80'(wr_count), 80'd14);
	assert property (@(posedge i_CLK) disable iff (i_RST)
		o_uart_tx_valid |-> $past(i_uart_tx_ready))
		else report_error("tx valid pulsed while tx ready was low");
	assert property (@(posedge i_CLK) disable iff (i_RST) o_error |=> o_error)
		else report_error("o_error dropped before reset");

	// ========================================
	// stimulus helpers entered 1 ns after an edge
	// ========================================
	task automatic step(input int n);
		repeat (n) @(posedge i_CLK);
		#1;
	endtask

	task automatic send_word(input host_word_t w);
		i_uart_rx_data  = w;
		i_uart_rx_valid = 1'b1;
		step(1);
		i_uart_rx_valid = 1'b0;
	endtask

	task automatic load_reg(input reg_addr_t a, input reg_data_t d);
		load_en   = 1'b1;
		load_addr = a;
		load_data = d;
		step(1);
		load_en = 1'b0;
	endtask

	task automatic wait_frame(output host_frame_t f);
		while (frames.size() == 0)
			step(1);
		f = frames.pop_front();
	endtask

	task automatic wait_polls(input int n);
		int base;
		base = poll_reads;
		while (poll_reads < base + n)
			step(1);
	endtask

	task automatic expect_touch_frame(input touch_status_t exp);
		host_frame_t f;
		wait_frame(f);
		assert (f == {TAG_TOUCH, 4'h0, exp, 56'b0})
			else report_mismatch("o_uart_tx_data", f, {TAG_TOUCH, 4'h0, exp, 56'b0});
	endtask

	// ========================================
	// test sequence
	// ========================================
	initial begin
		reg_addr_t     rd_addr;
		reg_data_t     rd_byte;
		reg_data_t     s0;
		reg_data_t     s1;
		touch_status_t exp_status;
		host_frame_t   frame;
		int            reads_at_stop;

		void'($urandom(32'h3bd3cc83));
		i_RST           = 1'b1;
		i_uart_rx_data  = '0;
		i_uart_rx_valid = 1'b0;
		i_uart_tx_ready = 1'b1;
		i_mpr_init_done = 1'b0;
		load_en         = 1'b0;
		load_addr       = '0;
		load_data       = '0;
		fail_arm        = 1'b0;
		step(4);
		i_RST = 1'b0;
		assert (!o_uart_tx_valid && !o_mpr_wr_en && !o_mpr_rd_en && !o_chip_set
			&& !o_run_set && !o_core_busy && !o_error)
			else report_error("outputs not low after reset");

		// setting table
		step(5);
		i_mpr_init_done = 1'b1;
		while (!o_chip_set)
			step(1);

		// single register read
		rd_addr = 8'($urandom);
		rd_byte = 8'($urandom);
		load_reg(rd_addr, rd_byte);
		send_word({CMD_READ_REG, rd_addr});
		wait_frame(frame);
		assert (frame == {TAG_READ_REG, rd_addr, rd_byte, 56'b0})
			else report_mismatch("o_uart_tx_data", frame,
				{TAG_READ_REG, rd_addr, rd_byte, 56'b0});

		// run and touch polling
		s0 = 8'($urandom);
		s1 = 8'($urandom);
		load_reg(8'h00, s0);
		load_reg(8'h01, s1);
		exp_status = {s1[3:0], s0};
		send_word({CMD_RUN, 8'h00});
		while (!o_run_set)
			step(1);
		assert (last_wr_addr == 8'h5E && last_wr_data == 8'h8F)
			else report_mismatch("o_mpr_reg_addr/o_mpr_wr_data",
				80'({last_wr_addr, last_wr_data}), 80'h5E8F);
		repeat (3) expect_touch_frame(exp_status);
		assert (o_touch_status == exp_status)
			else report_mismatch("o_touch_status", 80'(o_touch_status), 80'(exp_status));

		// two status changes while the transmitter is held off
		i_uart_tx_ready = 1'b0;
		step(2);
		frames.delete();
		for (int k = 0; k < 2; k++) begin
			s0 = 8'($urandom);
			s1 = 8'($urandom);
			load_reg(8'h00, s0);
			load_reg(8'h01, s1);
			wait_polls(5); // a full pair after the loads
		end
		step(1 + int'($urandom % 16));
		assert (frames.size() == 0)
			else report_error("frame sent while tx ready was low");
		exp_status      = {s1[3:0], s0};
		i_uart_tx_ready = 1'b1;
		expect_touch_frame(exp_status);
		assert (o_touch_status == exp_status)
			else report_mismatch("o_touch_status", 80'(o_touch_status), 80'(exp_status));

		// stop
		send_word({CMD_STOP, 8'h00});
		while (o_run_set)
			step(1);
		assert (last_wr_addr == 8'h5E && last_wr_data == 8'h00)
			else report_mismatch("o_mpr_reg_addr/o_mpr_wr_data",
				80'({last_wr_addr, last_wr_data}), 80'h5E00);
		assert (!o_core_busy) else report_error("o_core_busy still high after stop");
		reads_at_stop = rd_count;
		step(40);
		assert (rd_count == reads_at_stop)
			else report_error("status reads went on after stop");
		frames.delete();

		// fail on a host read
		fail_arm = 1'b1;
		send_word({CMD_READ_REG, 8'($urandom)});
		while (!o_error)
			step(1);
		fail_arm = 1'b0;
		step(20);
		assert (frames.size() == 0) else report_error("frame sent for a failed read");

		$display("All checks passed");
		$finish;
	end

endmodule

// File: project.f
source/touch_pkg.sv
source/host_cmd_decode.sv
source/touch_sequencer.sv
source/host_frame_builder.sv
source/touch_core.sv
dv/mpr121_bus_model.sv
dv/touch_core_tb.sv

// File: source/host_cmd_decode.sv
// ========================================
// host_cmd_decode
// turns received 16-bit host words into a
// run level and single register read requests
// ========================================
`timescale 1ns/1ps

module host_cmd_decode
	import touch_pkg::*;
(
	input  logic       i_CLK,
	input  logic       i_RST,
	input  host_word_t i_rx_data,
	input  logic       i_rx_valid,
	output logic       o_run_mode,
	output logic       o_read_req,
	output reg_addr_t  o_read_addr
);

	logic [7:0] w_cmd; // command code
	reg_addr_t  w_arg; // argument byte

	assign w_cmd = i_rx_data[15:8];
	assign w_arg = i_rx_data[7:0];

	// ========================================
	// run level and read pulse
	// ========================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			o_run_mode <= 1'b0;
			o_read_req <= 1'b0;
		end else begin
			o_read_req <= 1'b0; // one cycle only
			if (i_rx_valid) begin
				case (w_cmd)
					CMD_RUN:      o_run_mode <= 1'b1;
					CMD_STOP:     o_run_mode <= 1'b0;
					CMD_READ_REG: o_read_req <= 1'b1;
					default: ;    // unknown codes dropped
				endcase
			end
		end
	end

	// register address travels with the read pulse
	always_ff @(posedge i_CLK) begin
		if (i_rx_valid && (w_cmd == CMD_READ_REG)) begin
			o_read_addr <= w_arg;
		end
	end

endmodule

// File: source/host_frame_builder.sv
// ========================================
// host_frame_builder
// keeps one pending touch frame and one pending
// register frame, sends them when the UART
// transmitter is ready, touch first
// ========================================
`timescale 1ns/1ps

module host_frame_builder
	import touch_pkg::*;
(
	input  logic          i_CLK,
	input  logic          i_RST,
	input  logic          i_status_valid,
	input  touch_status_t i_touch_status,
	input  logic          i_read_done,
	input  reg_addr_t     i_read_addr,
	input  reg_data_t     i_read_data,
	input  logic          i_tx_ready,
	output host_frame_t   o_tx_data,
	output logic          o_tx_valid
);

	logic          r_touch_pend;
	logic          r_read_pend;
	touch_status_t r_touch_status; // newest status replaces older one
	reg_addr_t     r_read_addr;
	reg_data_t     r_read_data;
	host_frame_t   w_touch_frame;
	host_frame_t   w_read_frame;
	logic          w_send_touch;
	logic          w_send_read;

	assign w_touch_frame = {TAG_TOUCH, 16'(r_touch_status), 56'b0};
	assign w_read_frame  = {TAG_READ_REG, r_read_addr, r_read_data, 56'b0};
	assign w_send_touch  = i_tx_ready && r_touch_pend;
	assign w_send_read   = i_tx_ready && !r_touch_pend && r_read_pend;

	// ========================================
	// pending flags and valid pulse
	// ========================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_touch_pend <= 1'b0;
			r_read_pend  <= 1'b0;
			o_tx_valid   <= 1'b0;
		end else begin
			o_tx_valid <= w_send_touch || w_send_read;
			if (w_send_touch) r_touch_pend <= 1'b0;
			if (w_send_read)  r_read_pend  <= 1'b0;
			// new arrivals win over a same-cycle send
			if (i_status_valid) r_touch_pend <= 1'b1;
			if (i_read_done)    r_read_pend  <= 1'b1;
		end
	end

	always_ff @(posedge i_CLK) begin
		if (i_status_valid) r_touch_status <= i_touch_status;
		if (i_read_done) begin
			r_read_addr <= i_read_addr;
			r_read_data <= i_read_data;
		end
		if (w_send_touch)
			o_tx_data <= w_touch_frame;
		else if (w_send_read)
			o_tx_data <= w_read_frame;
	end

endmodule

// File: source/touch_core.sv
// ========================================
// touch_core
// MPR121 touch sensor core with host command
// decode and UART frame output
// ========================================
`timescale 1ns/1ps

module touch_core
	import touch_pkg::*;
(
	input  logic          i_CLK,
	input  logic          i_RST,
	// UART side
	input  host_word_t    i_uart_rx_data,
	input  logic          i_uart_rx_valid,
	input  logic          i_uart_tx_ready,
	output host_frame_t   o_uart_tx_data,
	output logic          o_uart_tx_valid,
	// MPR121 register-access controller
	input  reg_data_t     i_mpr_rd_data,
	input  logic          i_mpr_init_done,
	input  logic          i_mpr_busy,
	input  logic          i_mpr_fail,
	output reg_addr_t     o_mpr_reg_addr,
	output reg_data_t     o_mpr_wr_data,
	output logic          o_mpr_wr_en,
	output logic          o_mpr_rd_en,
	// system status
	output touch_status_t o_touch_status,
	output logic          o_chip_set,
	output logic          o_run_set,
	output logic          o_core_busy,
	output logic          o_error
);

	logic      w_run_mode;
	logic      w_read_req;
	reg_addr_t w_read_addr;
	logic      w_status_valid;
	logic      w_read_done;
	reg_addr_t w_read_addr_echo;
	reg_data_t w_read_data;

	host_cmd_decode u_decode (
		.i_CLK       (i_CLK),
		.i_RST       (i_RST),
		.i_rx_data   (i_uart_rx_data),
		.i_rx_valid  (i_uart_rx_valid),
		.o_run_mode  (w_run_mode),
		.o_read_req  (w_read_req),
		.o_read_addr (w_read_addr)
	);

	touch_sequencer u_execute (
		.i_CLK            (i_CLK),
		.i_RST            (i_RST),
		.i_init_done      (i_mpr_init_done),
		.i_run_mode       (w_run_mode),
		.i_read_req       (w_read_req),
		.i_read_addr      (w_read_addr),
		.i_mpr_rd_data    (i_mpr_rd_data),
		.i_mpr_busy       (i_mpr_busy),
		.i_mpr_fail       (i_mpr_fail),
		.o_mpr_reg_addr   (o_mpr_reg_addr),
		.o_mpr_wr_data    (o_mpr_wr_data),
		.o_mpr_wr_en      (o_mpr_wr_en),
		.o_mpr_rd_en      (o_mpr_rd_en),
		.o_touch_status   (o_touch_status),
		.o_status_valid   (w_status_valid),
		.o_read_done      (w_read_done),
		.o_read_addr_echo (w_read_addr_echo),
		.o_read_data      (w_read_data),
		.o_chip_set       (o_chip_set),
		.o_run_set        (o_run_set),
		.o_core_busy      (o_core_busy),
		.o_error          (o_error)
	);

	host_frame_builder u_result (
		.i_CLK          (i_CLK),
		.i_RST          (i_RST),
		.i_status_valid (w_status_valid),
		.i_touch_status (o_touch_status),
		.i_read_done    (w_read_done),
		.i_read_addr    (w_read_addr_echo),
		.i_read_data    (w_read_data),
		.i_tx_ready     (i_uart_tx_ready),
		.o_tx_data      (o_uart_tx_data),
		.o_tx_valid     (o_uart_tx_valid)
	);

endmodule

// File: source/touch_pkg.sv
// ========================================
// touch_pkg
// shared widths, host command codes, frame tags
// and the MPR121 recommended setting table
// ========================================
package touch_pkg;

	// ========================================
	// widths with a meaning
	// ========================================
	typedef logic [7:0]  reg_addr_t;     // MPR121 register address
	typedef logic [7:0]  reg_data_t;     // MPR121 register byte
	typedef logic [11:0] touch_status_t; // ELE0..ELE11 touch bits
	typedef logic [15:0] host_word_t;    // {command, argument}
	typedef logic [79:0] host_frame_t;   // frame to the UART transmitter

	// host command codes, upper byte of a host word
	localparam logic [7:0] CMD_RUN      = 8'h52; // 'R'
	localparam logic [7:0] CMD_STOP     = 8'h53; // 'S'
	localparam logic [7:0] CMD_READ_REG = 8'h6D; // 'm'

	// first byte of every transmit frame
	localparam logic [7:0] TAG_TOUCH    = 8'hBB;
	localparam logic [7:0] TAG_READ_REG = 8'h6D;

	// ========================================
	// MPR121 setting table, written in order
	// ========================================
	localparam int MPR_SETTING_COUNT = 14;

	localparam reg_addr_t MPR_SETTING_ADDR [MPR_SETTING_COUNT] = '{
		8'h2B, 8'h2C, 8'h2D, 8'h2E, 8'h2F, 8'h30, 8'h31,
		8'h32, 8'h33, 8'h34, 8'h35, 8'h5B, 8'h5C, 8'h5D
	};

	// baseline filter, debounce and CDC/CDT values
	localparam reg_data_t MPR_SETTING_DATA [MPR_SETTING_COUNT] = '{
		8'h01, 8'h01, 8'h0E, 8'h00, 8'h01, 8'h05, 8'h01,
		8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h10, 8'h20
	};

	// electrode config starts and stops scanning
	localparam reg_addr_t MPR_ELE_CONFIG_REG = 8'h5E;
	localparam reg_data_t ELE_RUN            = 8'h8F; // all 12 electrodes
	localparam reg_data_t ELE_STOP           = 8'h00;

	localparam reg_addr_t MPR_TOUCH_STATUS_0_REG = 8'h00; // ELE0..ELE7
	localparam reg_addr_t MPR_TOUCH_STATUS_1_REG = 8'h01; // ELE8..ELE11 in low nibble

endpackage

// File: source/touch_sequencer.sv
// ========================================
// touch_sequencer
// MPR121 setting, run/stop, touch status
// polling and host register reads through
// the register-access controller
// ========================================
`timescale 1ns/1ps

module touch_sequencer
	import touch_pkg::*;
(
	input  logic          i_CLK,
	input  logic          i_RST,
	input  logic          i_init_done,
	input  logic          i_run_mode,
	input  logic          i_read_req,
	input  reg_addr_t     i_read_addr,
	input  reg_data_t     i_mpr_rd_data,
	input  logic          i_mpr_busy,
	input  logic          i_mpr_fail,
	output reg_addr_t     o_mpr_reg_addr,
	output reg_data_t     o_mpr_wr_data,
	output logic          o_mpr_wr_en,
	output logic          o_mpr_rd_en,
	output touch_status_t o_touch_status,
	output logic          o_status_valid,
	output logic          o_read_done,
	output reg_addr_t     o_read_addr_echo,
	output reg_data_t     o_read_data,
	output logic          o_chip_set,
	output logic          o_run_set,
	output logic          o_core_busy,
	output logic          o_error
);

	typedef enum logic [3:0] {
		ST_WAIT_INIT,
		ST_SETTING,
		ST_STANDBY,
		ST_RUN_START,
		ST_POLL,
		ST_STOP,
		ST_READ_REG,
		ST_ACC_EN,   // enable pulse
		ST_ACC_SKIP, // busy not valid yet
		ST_ACC_WAIT  // wait busy low, then finish
	} state_t;

	state_t     r_state;
	state_t     r_ret_state;  // who started the access
	logic       r_acc_write;  // write or read access
	logic [3:0] r_tbl_idx;    // setting table index
	logic       r_status_sel; // high selects status 1
	logic       r_run_mode_d;
	logic       r_run_req;    // run level rose and waits to be served

	// ========================================
	// main FSM
	// ========================================
	always_ff @(posedge i_CLK or posedge i_RST) begin
		if (i_RST) begin
			r_state          <= ST_WAIT_INIT;
			r_ret_state      <= ST_STANDBY;
			r_acc_write      <= 1'b0;
			r_tbl_idx        <= 4'd0;
			r_status_sel     <= 1'b0;
			r_run_mode_d     <= 1'b0;
			r_run_req        <= 1'b0;
			o_mpr_reg_addr   <= '0;
			o_mpr_wr_data    <= '0;
			o_mpr_wr_en      <= 1'b0;
			o_mpr_rd_en      <= 1'b0;
			o_touch_status   <= '0;
			o_status_valid   <= 1'b0;
			o_read_done      <= 1'b0;
			o_read_addr_echo <= '0;
			o_read_data      <= '0;
			o_chip_set       <= 1'b0;
			o_run_set        <= 1'b0;
			o_core_busy      <= 1'b0;
			o_error          <= 1'b0;
		end else begin
			o_mpr_wr_en    <= 1'b0;
			o_mpr_rd_en    <= 1'b0;
			o_status_valid <= 1'b0;
			o_read_done    <= 1'b0;

			// rising run level is remembered until served or dropped
			r_run_mode_d <= i_run_mode;
			if (!i_run_mode)
				r_run_req <= 1'b0;
			else if (!r_run_mode_d)
				r_run_req <= 1'b1;

			case (r_state)
				ST_WAIT_INIT: begin
					r_tbl_idx <= 4'd0;
					if (i_init_done)
						r_state <= ST_SETTING;
				end

				ST_SETTING: begin
					o_mpr_reg_addr <= MPR_SETTING_ADDR[r_tbl_idx];
					o_mpr_wr_data  <= MPR_SETTING_DATA[r_tbl_idx];
					r_acc_write    <= 1'b1;
					r_ret_state    <= ST_SETTING;
					r_state        <= ST_ACC_EN;
				end

				ST_STANDBY: begin
					// nothing served until the table is written
					if (o_chip_set && r_run_req) begin
						r_run_req <= 1'b0;
						r_state   <= ST_RUN_START;
					end else if (o_chip_set && i_read_req) begin
						o_read_addr_echo <= i_read_addr;
						r_state          <= ST_READ_REG;
					end
				end

				ST_RUN_START: begin
					o_mpr_reg_addr <= MPR_ELE_CONFIG_REG;
					o_mpr_wr_data  <= ELE_RUN;
					r_acc_write    <= 1'b1;
					r_ret_state    <= ST_RUN_START;
					r_status_sel   <= 1'b0;
					r_state        <= ST_ACC_EN;
				end

				ST_POLL: begin
					if (!i_run_mode) begin
						r_state <= ST_STOP;
					end else begin
						o_mpr_reg_addr <= r_status_sel ? MPR_TOUCH_STATUS_1_REG
							: MPR_TOUCH_STATUS_0_REG;
						r_acc_write    <= 1'b0;
						r_ret_state    <= ST_POLL;
						r_state        <= ST_ACC_EN;
					end
				end

				ST_STOP: begin
					o_mpr_reg_addr <= MPR_ELE_CONFIG_REG;
					o_mpr_wr_data  <= ELE_STOP;
					r_acc_write    <= 1'b1;
					r_ret_state    <= ST_STOP;
					r_state        <= ST_ACC_EN;
				end

				ST_READ_REG: begin
					o_mpr_reg_addr <= o_read_addr_echo;
					r_acc_write    <= 1'b0;
					r_ret_state    <= ST_READ_REG;
					r_state        <= ST_ACC_EN;
				end

				// ========================================
				// shared access sub-sequence
				// ========================================
				ST_ACC_EN: begin
					o_mpr_wr_en <= r_acc_write;
					o_mpr_rd_en <= !r_acc_write;
					r_state     <= ST_ACC_SKIP;
				end

				ST_ACC_SKIP: r_state <= ST_ACC_WAIT;

				ST_ACC_WAIT: begin
					if (!i_mpr_busy) begin
						if (i_mpr_fail) begin
							o_error     <= 1'b1; // sticky until reset
							o_run_set   <= 1'b0;
							o_core_busy <= 1'b0;
							r_state     <= ST_STANDBY;
						end else begin
							case (r_ret_state)
								ST_SETTING: begin
									if (r_tbl_idx == 4'(MPR_SETTING_COUNT - 1)) begin
										o_chip_set <= 1'b1;
										r_state    <= ST_STANDBY;
									end else begin
										r_tbl_idx <= r_tbl_idx + 4'd1;
										r_state   <= ST_SETTING;
									end
								end
								ST_RUN_START: begin
									o_run_set   <= 1'b1;
									o_core_busy <= 1'b1;
									r_state     <= ST_POLL;
								end
								ST_POLL: begin
									if (r_status_sel) begin
										o_touch_status[11:8] <= i_mpr_rd_data[3:0];
										o_status_valid       <= 1'b1; // full status ready
									end else begin
										o_touch_status[7:0] <= i_mpr_rd_data;
									end
									r_status_sel <= !r_status_sel;
									r_state      <= ST_POLL;
								end
								ST_STOP: begin
									o_run_set   <= 1'b0;
									o_core_busy <= 1'b0;
									r_state     <= ST_STANDBY;
								end
								default: begin // host register read
									o_read_data <= i_mpr_rd_data;
									o_read_done <= 1'b1;
									r_state     <= ST_STANDBY;
								end
							endcase
						end
					end
				end

				default: r_state <= ST_WAIT_INIT;
			endcase
		end
	end

endmodule
